//--- runSim.sh
#!/bin/sh
# Builds the SPI memory testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing --assert -f verilog.f --top-module spiMemoryTb -Mdir "$buildDir"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/VspiMemoryTb" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

# The testbench prints the fail message on any failed check and on a timeout
if grep -q "Test failures found" "$logFile"; then
    exit 1
fi
exit 0

//--- source/dataMemory.sv
`timescale 1ns/10ps

module dataMemory
    import memoryMapPkg::*;
(
    input  logic                 clk,
    input  logic                 writeEnable,
    input  logic [addrWidth-1:0] address,
    input  logic [dataWidth-1:0] writeData,
    output logic [dataWidth-1:0] readData
);

    logic [dataWidth-1:0] memWords [memDepth];

    // Single port: the write and the registered read share one address
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            memWords[address] <= writeData;
        end
    end

    // Read data follows the address one clk later, with or without a request
    always_ff @(posedge clk) begin
        readData <= memWords[address];
    end

endmodule

//--- source/inputConditioner.sv
`timescale 1ns/10ps

module inputConditioner #(
    parameter int debounceCycles = 2,
    parameter logic resetLevel = 1'b0
) (
    input  logic clk,
    input  logic rstN,
    input  logic noisyIn,
    output logic conditioned,
    output logic positiveEdge,
    output logic negativeEdge
);

    localparam int countWidth = $clog2(debounceCycles + 2);
    localparam logic [countWidth-1:0] countLimit = countWidth'(debounceCycles);

    logic syncStage1;
    logic syncStage2;
    logic [countWidth-1:0] stableCount;
    logic levelDiffers;

    // Two flops bring the pin into the clk domain
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            syncStage1 <= resetLevel;
            syncStage2 <= resetLevel;
        end else begin
            syncStage1 <= noisyIn;
            syncStage2 <= syncStage1;
        end
    end

    assign levelDiffers = (syncStage2 != conditioned);

    // A new level is taken only after it has stayed put long enough
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stableCount <= '0;
            conditioned <= resetLevel;
            positiveEdge <= 1'b0;
            negativeEdge <= 1'b0;
        end else begin
            positiveEdge <= 1'b0;
            negativeEdge <= 1'b0;
            if (!levelDiffers) begin
                stableCount <= '0;                 // Glitch or no change, start over
            end else if (stableCount == countLimit) begin
                stableCount <= '0;
                conditioned <= syncStage2;
                positiveEdge <= syncStage2;        // Pulses line up with the level change
                negativeEdge <= !syncStage2;
            end else begin
                stableCount <= stableCount + 1'b1;
            end
        end
    end

endmodule

//--- source/memoryMapPkg.sv
package memoryMapPkg;

    // Register memory seen by the SPI master
    localparam int addrWidth = 7;                  // Seven address bits from the command byte
    localparam int dataWidth = 8;                  // One byte per register

    // Every address in the command byte maps to a word
    localparam int memDepth = 128;

endpackage

//--- source/spiControlFsm.sv
`timescale 1ns/10ps

module spiControlFsm
    import spiProtocolPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic sclkRise,
    input  logic sclkFall,
    input  logic csLevel,
    input  logic readFlag,
    output logic addrLatchEnable,
    output logic memWriteEnable,
    output logic shiftLoad,
    output logic misoEnable
);

    ctrlState state;
    logic [bitCountWidth-1:0] bitCount;
    logic lastBit;
    logic lastFall;
    logic readPhaseDone;                           // Marks that all eight data rises have been seen in readData

    assign lastBit = (bitCount == bitCountWidth'(frameBits - 1));

    // The falling sclk that ends the command phase reaches readData as well,
    // so the read phase ends on the fall that follows its eighth rise
    assign lastFall = sclkFall && (bitCount == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
            bitCount <= '0;
            memWriteEnable <= 1'b0;
        end else begin
            memWriteEnable <= 1'b0;
            if (csLevel) begin
                // Chip select released so the frame is dropped wherever it stands
                state <= idle;
                bitCount <= '0;
            end else begin
                case (state)
                    idle: begin
                        state <= command;
                        bitCount <= '0;
                    end
                    command: begin
                        if (sclkRise) begin
                            bitCount <= bitCount + 1'b1;        // Wraps to zero on the eighth
                            if (lastBit) begin
                                state <= decode;
                            end
                        end
                    end
                    decode: begin
                        state <= readFlag ? memRead : writeData;
                    end
                    writeData: begin
                        if (sclkRise) begin
                            bitCount <= bitCount + 1'b1;
                            if (lastBit) begin
                                // Shift register holds the full byte by the next clk
                                memWriteEnable <= 1'b1;
                                state <= idle;
                            end
                        end
                    end
                    memRead: begin
                        state <= spiProtocolPkg::shiftLoad;     // Memory output valid next clk
                    end
                    spiProtocolPkg::shiftLoad: begin
                        state <= readData;
                    end
                    readData: begin
                        if (sclkRise) begin
                            bitCount <= bitCount + 1'b1;        // Wraps to zero on the eighth
                        end else if (lastFall && readPhaseDone) begin
                            state <= idle;
                        end
                    end
                    default: begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readPhaseDone <= 1'b0;
        end else if (state != readData || csLevel) begin
            readPhaseDone <= 1'b0;
        end else if (sclkRise && lastBit) begin
            readPhaseDone <= 1'b1;
        end
    end

    // Strobes decode straight from the state and each state lasts one clk
    assign addrLatchEnable = (state == decode);
    assign shiftLoad = (state == spiProtocolPkg::shiftLoad);
    assign misoEnable = (state == readData);

endmodule

//--- source/spiMemory.sv
`timescale 1ns/10ps

module spiMemory
    import memoryMapPkg::*;
    import spiProtocolPkg::*;
#(
    parameter int debounceCycles = 2
) (
    input  logic clk,
    input  logic rstN,
    input  logic sclk,
    input  logic csN,
    input  logic mosi,
    output logic miso,
    output logic misoEnable
);

    localparam int inputCount = 3;
    localparam int sclkIndex = 0;
    localparam int csIndex = 1;
    localparam int mosiIndex = 2;

    logic [inputCount-1:0] rawInputs;
    logic [inputCount-1:0] inputLevel;
    logic [inputCount-1:0] inputRise;
    logic [inputCount-1:0] inputFall;

    logic [frameBits-1:0] shiftData;
    logic [dataWidth-1:0] memReadData;
    logic [addrWidth-1:0] latchedAddr;
    logic addrLatchEnable;
    logic memWriteEnable;
    logic loadShift;
    logic shiftMiso;

    assign rawInputs = {mosi, csN, sclk};

    // One conditioner per pin, csN idles high so its conditioner resets high
    for (genvar inputIndex = 0; inputIndex < inputCount; inputIndex++) begin : conditionerGen
        inputConditioner #(
            .debounceCycles(debounceCycles),
            .resetLevel    (inputIndex == csIndex)
        ) inputConditioner_i (
            .clk         (clk),
            .rstN        (rstN),
            .noisyIn     (rawInputs[inputIndex]),
            .conditioned (inputLevel[inputIndex]),
            .positiveEdge(inputRise[inputIndex]),
            .negativeEdge(inputFall[inputIndex])
        );
    end

    spiShiftRegister spiShiftRegister_i (
        .clk        (clk),
        .rstN       (rstN),
        .serialIn   (inputLevel[mosiIndex]),
        .shiftIn    (inputRise[sclkIndex]),        // Mode 0 samples on the rising sclk
        .shiftOut   (inputFall[sclkIndex]),
        .load       (loadShift),
        .loadData   (memReadData),
        .parallelOut(shiftData),
        .miso       (shiftMiso)
    );

    spiControlFsm spiControlFsm_i (
        .clk            (clk),
        .rstN           (rstN),
        .sclkRise       (inputRise[sclkIndex]),
        .sclkFall       (inputFall[sclkIndex]),
        .csLevel        (inputLevel[csIndex]),
        .readFlag       (shiftData[readFlagIndex]),
        .addrLatchEnable(addrLatchEnable),
        .memWriteEnable (memWriteEnable),
        .shiftLoad      (loadShift),
        .misoEnable     (misoEnable)
    );

    // Address bits sit above the read flag once the command byte is in
    always_ff @(posedge clk) begin
        if (addrLatchEnable) begin
            latchedAddr <= shiftData[frameBits-1:readFlagIndex+1];
        end
    end

    dataMemory dataMemory_i (
        .clk        (clk),
        .writeEnable(memWriteEnable),
        .address    (latchedAddr),
        .writeData  (shiftData),
        .readData   (memReadData)
    );

    // Stands in for the tristate pad, miso only drives during a read
    assign miso = shiftMiso & misoEnable;

endmodule

//--- source/spiProtocolPkg.sv
package spiProtocolPkg;

    // One frame is a command byte followed by a data byte
    localparam int frameBits = 8;                  // Length of each phase in sclk cycles
    localparam int bitCountWidth = 3;              // Enough to count the bits of one phase

    // Command byte layout, most significant bit first on the wire:
    //   bits 7..1 hold the register address, bit 0 selects read (1) or write (0)
    localparam int readFlagIndex = 0;

    // Controller states in frame order
    typedef enum logic [2:0] {
        idle,                                      // Waiting for csN to go low
        command,                                   // Shifting in address and read flag
        decode,                                    // Address latched, branch on read flag
        writeData,                                 // Shifting in the write byte
        memRead,                                   // Memory read latency
        shiftLoad,                                 // Read data copied into the shift register
        readData                                   // Shifting the read byte out on miso
    } ctrlState;

endpackage

//--- source/spiShiftRegister.sv
`timescale 1ns/10ps

module spiShiftRegister
    import memoryMapPkg::*;
    import spiProtocolPkg::*;
(
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 serialIn,
    input  logic                 shiftIn,
    input  logic                 shiftOut,
    input  logic                 load,
    input  logic [dataWidth-1:0] loadData,
    output logic [frameBits-1:0] parallelOut,
    output logic                 miso
);

    // Shift contents: mosi enters at bit 0 and the byte leaves from the top.
    // Load wins over a shift landing in the same clk
    always_ff @(posedge clk) begin
        if (load) begin
            parallelOut <= loadData;
        end else if (shiftIn) begin
            parallelOut <= {parallelOut[frameBits-2:0], serialIn};
        end
    end

    // The miso bit is held in its own flop so it only moves on a falling sclk.
    // After a rising sclk the top bit already holds the next bit to send,
    // so the falling sclk just copies it out
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            miso <= 1'b0;
        end else if (load) begin
            miso <= loadData[dataWidth-1];         // MSB is ready before the first data rise
        end else if (shiftOut) begin
            miso <= parallelOut[frameBits-1];
        end
    end

    // A falling sclk between the load and the first data rise sees the same
    // top bit again, so miso keeps the MSB through it

endmodule

//--- verification/spiMasterTasks.svh
`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

// Every drive happens a short fixed delay after the rising clk edge
task automatic waitClocks(input int count);
    repeat (count) @(posedge clk);
    #(driveDelayNs);
endtask

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
endfunction

// One LFSR step per bit taken, the low bit is the output
task automatic randomBits(input int bitCount, output logic [31:0] value);
    int bitIndex;
    value = '0;
    for (bitIndex = 0; bitIndex < bitCount; bitIndex++) begin
        value = {value[30:0], lfsrState[0]};
        lfsrState = lfsrStep(lfsrState);
    end
endtask

task automatic compareByte(input string signalName, input logic [7:0] expected,
                           input logic [7:0] actual);
    assert (actual === expected) else begin
        $display("error at time %0t: %s expected %h, got %h", $time, signalName, expected, actual);
        errorCount++;
    end
endtask

task automatic requireCondition(input bit condition, input string description);
    assert (condition) else begin
        $display("check failed at time %0t: %s", $time, description);
        errorCount++;
    end
endtask

// Mode 0: mosi is set up while sclk is low, miso is taken just before sclk rises
task automatic driveRiseHalf(input logic mosiBit, output logic misoBit, output logic enableBit);
    mosi = mosiBit;
    waitClocks(sclkHalfClocks);
    misoBit = miso;
    enableBit = misoEnable;
    sclk = 1'b1;
endtask

task automatic driveFallHalf();
    waitClocks(sclkHalfClocks);
    sclk = 1'b0;
endtask

// Sends bitLimit bits of {address, read flag, data} and collects miso from the data phase
task automatic runFrame(
    input  logic [addrWidth-1:0] address,
    input  logic                 readNotWrite,
    input  logic [dataWidth-1:0] writeByte,
    input  int                   bitLimit,
    output logic [dataWidth-1:0] readByte,
    output int                   enableMisses
);
    logic [2*frameBits-1:0] frameWord;
    logic misoBit;
    logic enableBit;
    int bitIndex;
    frameWord = {address, readNotWrite, writeByte};
    readByte = '0;
    enableMisses = 0;
    csN = 1'b0;
    commandPhase = 1'b1;
    for (bitIndex = 0; bitIndex < bitLimit; bitIndex++) begin
        driveRiseHalf(frameWord[2*frameBits-1], misoBit, enableBit);
        frameWord = frameWord << 1;
        if (bitIndex == frameBits - 1) begin
            commandPhase = 1'b0;                   // Last command bit has just gone out
        end
        if (bitIndex >= frameBits) begin
            readByte = {readByte[dataWidth-2:0], misoBit};
            if (readNotWrite && enableBit !== 1'b1) begin
                enableMisses++;
            end
        end
        driveFallHalf();
    end
    commandPhase = 1'b0;
    waitClocks(sclkHalfClocks);                    // Let the last falling sclk reach the slave
    csN = 1'b1;
    waitClocks(frameGapClocks);
endtask

`endif

//--- verification/spiMemoryTb.sv
`timescale 1ns/10ps

module spiMemoryTb
    import memoryMapPkg::*;
    import spiProtocolPkg::*;
();

    localparam int debounceCycles = 2;
    localparam int clkHalfNs = 4;                  // 8 ns clk period
    localparam int driveDelayNs = 1;
    localparam int resetClocks = 5;
    localparam int sclkHalfClocks = 8;             // sclk runs at clk/16
    localparam int frameGapClocks = 16;            // csN high time between frames
    localparam logic [31:0] lfsrSeed = 32'h9ad4;
    localparam int idleCheckClocks = 64;
    localparam int fillCount = 16;
    localparam int abortBits = 12;

    // A frame with csN setup and gap stays under 300 clk and the tests run about 40 of them
    localparam int frameClocks = 300;
    localparam int plannedFrames = 40;
    localparam int timeoutCycles = plannedFrames * frameClocks + 8000;

    logic clk = 1'b0;
    logic rstN;
    logic sclk;
    logic csN;
    logic mosi;
    logic miso;
    logic misoEnable;

    logic commandPhase;                            // High while the master sends command bits
    logic [31:0] lfsrState;
    logic [dataWidth-1:0] modelMem [memDepth];     // What the memory should hold
    int errorCount;
    int leakCount = 0;                             // Only the command phase monitor counts here
    int passedTests;
    int failedTests;
    int cycleCount = 0;

    `include "spiMasterTasks.svh"

    spiMemory #(
        .debounceCycles(debounceCycles)
    ) spiMemory_i (
        .clk       (clk),
        .rstN      (rstN),
        .sclk      (sclk),
        .csN       (csN),
        .mosi      (mosi),
        .miso      (miso),
        .misoEnable(misoEnable)
    );

    always #(clkHalfNs) clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the tests did not finish within %0d clk cycles", timeoutCycles);
            $display("Test failures found");
            $finish;
        end
    end

    // The slave must never drive miso while a command byte is coming in
    always @(negedge clk) begin
        if (commandPhase) begin
            assert (misoEnable === 1'b0) else begin
                $display("error at time %0t: misoEnable expected 0, got %b", $time, misoEnable);
                leakCount++;
            end
        end
    end

    task automatic writeRegister(input logic [addrWidth-1:0] address,
                                 input logic [dataWidth-1:0] value);
        logic [dataWidth-1:0] unusedByte;
        int unusedMisses;
        runFrame(address, 1'b0, value, 2 * frameBits, unusedByte, unusedMisses);
        modelMem[address] = value;
    endtask

    task automatic readRegister(input logic [addrWidth-1:0] address,
                                output logic [dataWidth-1:0] value, output int enableMisses);
        runFrame(address, 1'b1, 8'h00, 2 * frameBits, value, enableMisses);
    endtask

    task automatic reportTest(input string testName, input int errorsBefore);
        int newErrors;
        newErrors = errorCount + leakCount - errorsBefore;
        if (newErrors == 0) begin
            $display("%s: ok", testName);
            passedTests++;
        end else begin
            $display("%s: FAILED with %0d error(s)", testName, newErrors);
            failedTests++;
        end
    endtask

    task automatic testIdleAfterReset();
        int errorsBefore;
        int cycle;
        errorsBefore = errorCount + leakCount;
        for (cycle = 0; cycle < idleCheckClocks; cycle++) begin
            waitClocks(1);
            compareByte("miso", 8'h00, {7'b0, miso});
            compareByte("misoEnable", 8'h00, {7'b0, misoEnable});
        end
        reportTest("test 1 idle after reset", errorsBefore);
    endtask

    task automatic testWriteThenRead();
        logic [dataWidth-1:0] readByte;
        int errorsBefore;
        int enableMisses;
        errorsBefore = errorCount + leakCount;
        writeRegister(7'h2a, 8'hc3);
        readRegister(7'h2a, readByte, enableMisses);
        compareByte("read byte at 2a", 8'hc3, readByte);
        requireCondition(enableMisses == 0, "misoEnable was low during the read data phase");
        compareByte("misoEnable", 8'h00, {7'b0, misoEnable});   // Frame is over by now
        reportTest("test 2 write then read", errorsBefore);
    endtask

    task automatic testRandomFill();
        logic [addrWidth-1:0] pickedAddr [$];
        logic [addrWidth-1:0] candidate;
        logic [dataWidth-1:0] readByte;
        logic [31:0] randomValue;
        bit addrUsed [memDepth];
        int errorsBefore;
        int enableMisses;
        errorsBefore = errorCount + leakCount;
        foreach (addrUsed[slot]) begin
            addrUsed[slot] = 1'b0;
        end
        while (pickedAddr.size() < fillCount) begin
            randomBits(addrWidth, randomValue);
            candidate = randomValue[addrWidth-1:0];
            if (!addrUsed[candidate]) begin
                addrUsed[candidate] = 1'b1;
                pickedAddr.push_back(candidate);
                randomBits(dataWidth, randomValue);
                writeRegister(candidate, randomValue[dataWidth-1:0]);
            end
        end
        foreach (pickedAddr[entry]) begin
            readRegister(pickedAddr[entry], readByte, enableMisses);
            compareByte($sformatf("read byte at %h", pickedAddr[entry]),
                        modelMem[pickedAddr[entry]], readByte);
            requireCondition(enableMisses == 0, "misoEnable was low during a read data phase");
        end
        reportTest("test 3 random fill", errorsBefore);
    endtask

    task automatic testAbortedWrite();
        logic [dataWidth-1:0] readByte;
        int errorsBefore;
        int enableMisses;
        errorsBefore = errorCount + leakCount;
        writeRegister(7'h33, 8'h96);
        // csN goes high four bits into the data phase, the model keeps the old word
        runFrame(7'h33, 1'b0, 8'h69, abortBits, readByte, enableMisses);
        readRegister(7'h33, readByte, enableMisses);
        compareByte("read byte at 33 after abort", modelMem[7'h33], readByte);
        writeRegister(7'h33, 8'h4b);
        readRegister(7'h33, readByte, enableMisses);
        compareByte("read byte at 33 after rewrite", 8'h4b, readByte);
        requireCondition(enableMisses == 0, "misoEnable was low during the read data phase");
        reportTest("test 4 aborted write", errorsBefore);
    endtask

    task automatic testBackToBackReads();
        logic [dataWidth-1:0] firstByte;
        logic [dataWidth-1:0] secondByte;
        int errorsBefore;
        int firstMisses;
        int secondMisses;
        errorsBefore = errorCount + leakCount;
        writeRegister(7'h05, 8'h1e);
        writeRegister(7'h7a, 8'he1);
        readRegister(7'h05, firstByte, firstMisses);
        readRegister(7'h7a, secondByte, secondMisses);
        compareByte("read byte at 05", 8'h1e, firstByte);
        compareByte("read byte at 7a", 8'he1, secondByte);
        requireCondition(firstMisses + secondMisses == 0,
                         "misoEnable was low during a read data phase");
        reportTest("test 5 back-to-back reads", errorsBefore);
    endtask

    initial begin
        rstN = 1'b0;
        sclk = 1'b0;
        csN = 1'b1;
        mosi = 1'b0;
        commandPhase = 1'b0;
        lfsrState = lfsrSeed;
        errorCount = 0;
        passedTests = 0;
        failedTests = 0;
        repeat (resetClocks) @(posedge clk);
        #(driveDelayNs);
        rstN = 1'b1;

        testIdleAfterReset();
        testWriteThenRead();
        testRandomFill();
        testAbortedWrite();
        testBackToBackReads();

        $display("%0d tests run, %0d passed, %0d failed, %0d errors", passedTests + failedTests,
                 passedTests, failedTests, errorCount + leakCount);
        if (failedTests == 0 && errorCount + leakCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verification
source/spiProtocolPkg.sv
source/memoryMapPkg.sv
source/inputConditioner.sv
source/spiShiftRegister.sv
source/spiControlFsm.sv
source/dataMemory.sv
source/spiMemory.sv
verification/spiMemoryTb.sv
